// ==== vlog.f ====
source/gfx_pkg.sv
source/gfx_cmd_decode.sv
source/gfx_clear.sv
source/gfx_fill_rect.sv
source/gfx_fb_write.sv
source/gfx_top.sv
testbench/gfx_asserts.sv
testbench/gfx_checker.sv
testbench/gfx_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP       = gfx_tb
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/gfx_tb.sv ====
module gfx_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import gfx_pkg::*;

  localparam int n_tests     = 40;
  localparam int fb_pixels   = fb_width * fb_height;
  localparam int wait_limit  = 2 * fb_pixels + 200;  // cycles allowed for one job.
  localparam int cycle_limit = n_tests * (2 * fb_pixels + 200 + 20);

  logic                  clk = 1'b0;
  logic                  reset;
  gfx_cmd_t              cmd;
  logic                  cmd_valid;
  logic                  cmd_ready;
  logic                  stall;
  logic                  bad_cmd;
  logic                  done;
  logic [fb_x_bits-1:0]  rd_x;
  logic [fb_y_bits-1:0]  rd_y;
  logic [pixel_bits-1:0] rd_color;

  logic [pixel_bits-1:0] model [fb_pixels];  // reference framebuffer.

  logic   check_req;
  logic   check_ack;
  logic   exp_done;
  logic   exp_bad;
  int     test_num;
  int     pass_count;
  int     fail_count;
  int     cycles = 0;
  integer seed = 32'h4061_06e5;

  always #2 clk = ~clk;

  gfx_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .stall     (stall),
    .bad_cmd   (bad_cmd),
    .done      (done),
    .rd_x      (rd_x),
    .rd_y      (rd_y),
    .rd_color  (rd_color)
  );

  gfx_checker chk0 (
    .clk        (clk),
    .reset      (reset),
    .cmd_ready  (cmd_ready),
    .done       (done),
    .bad_cmd    (bad_cmd),
    .rd_color   (rd_color),
    .model      (model),
    .check_req  (check_req),
    .exp_done   (exp_done),
    .exp_bad    (exp_bad),
    .test_num   (test_num),
    .rd_x       (rd_x),
    .rd_y       (rd_y),
    .check_ack  (check_ack),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ======================================================================
  // stimulus helpers.
  // ======================================================================

  // one clock; inputs change on the falling edge.
  task automatic tick();
    logic [31:0] r;
    @(negedge clk);
    r = $random(seed);
    stall = (test_num < 6) && (r % 10 < 3);  // about 30 percent early on.
  endtask

  function automatic gfx_cmd_t random_cmd();
    gfx_cmd_t             c;
    logic [31:0]          r;
    logic [fb_x_bits-1:0] t;
    r = $random(seed);
    c.color = r[3:0];
    c.x0    = r[7:4];
    c.x1    = r[11:8];
    c.y0    = r[15:12];
    c.y1    = r[19:16];
    case (r[23:20] % 10)
      0:       c.op = op_nop;
      1, 2:    c.op = op_clear;
      9:       c.op = op_bad;
      default: c.op = op_rect;
    endcase
    // three in four boxes are tidied up, the rest keep raw corners.
    if (r[25:24] != 2'd0) begin
      c.y0 = fb_y_bits'(int'(c.y0) % fb_height);
      c.y1 = fb_y_bits'(int'(c.y1) % fb_height);
      if (c.x1 < c.x0) begin
        t    = c.x0;
        c.x0 = c.x1;
        c.x1 = t;
      end
      if (c.y1 < c.y0) begin
        t    = c.y0;
        c.y0 = c.y1;
        c.y1 = t;
      end
    end
    return c;
  endfunction

  // rejected: reserved op, or a rectangle out of range or inverted.
  function automatic logic cmd_is_bad(input gfx_cmd_t c);
    if (c.op == op_bad) return 1'b1;
    if (c.op != op_rect) return 1'b0;
    return (int'(c.x1) >= fb_width) || (int'(c.y1) >= fb_height) ||
           (c.x1 < c.x0) || (c.y1 < c.y0);
  endfunction

  function automatic void apply_cmd(input gfx_cmd_t c);
    for (int y = 0; y < fb_height; y++) begin
      for (int x = 0; x < fb_width; x++) begin
        if ((c.op == op_clear) ||
            (x >= int'(c.x0) && x <= int'(c.x1) && y >= int'(c.y0) && y <= int'(c.y1))) begin
          model[y * fb_width + x] = c.color;
        end
      end
    end
  endfunction

  // ======================================================================
  // test sequence.
  // ======================================================================

  initial begin
    gfx_cmd_t c;
    int       waited;
    reset     = 1'b1;
    cmd       = '0;
    cmd_valid = 1'b0;
    stall     = 1'b0;
    check_req = 1'b0;
    exp_done  = 1'b0;
    exp_bad   = 1'b0;
    test_num  = 0;
    foreach (model[i]) model[i] = '0;
    repeat (3) tick();
    reset = 1'b0;
    repeat (2) tick();
    for (test_num = 0; test_num < n_tests; test_num++) begin
      c = random_cmd();
      if (test_num == 0) c.op = op_clear;  // frame is undefined before this.
      exp_bad  = cmd_is_bad(c);
      exp_done = ((c.op == op_clear) || (c.op == op_rect)) && !exp_bad;
      if (exp_done) apply_cmd(c);
      while (!cmd_ready) tick();
      cmd       = c;
      cmd_valid = 1'b1;
      tick();
      cmd_valid = 1'b0;
      if (exp_done) begin
        waited = 0;
        while (!done && waited < wait_limit) begin
          tick();
          waited++;
        end
        tick();  // cmd_ready comes back here.
      end else begin
        repeat (2) tick();  // lets the checker count a bad_cmd pulse.
      end
      check_req = 1'b1;
      wait (check_ack);
      check_req = 1'b0;
      wait (!check_ack);
    end
    $display("%0d checks, %0d passed, %0d failed", pass_count + fail_count,
             pass_count, fail_count);
    if (fail_count == 0 && pass_count == n_tests + 1) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== testbench/gfx_checker.sv ====
module gfx_checker (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           cmd_ready,
  input  logic                           done,
  input  logic                           bad_cmd,
  input  logic [gfx_pkg::pixel_bits-1:0] rd_color,
  input  logic [gfx_pkg::pixel_bits-1:0] model [gfx_pkg::fb_width * gfx_pkg::fb_height],
  input  logic                           check_req,
  input  logic                           exp_done,
  input  logic                           exp_bad,
  input  int                             test_num,
  output logic [gfx_pkg::fb_x_bits-1:0]  rd_x,
  output logic [gfx_pkg::fb_y_bits-1:0]  rd_y,
  output logic                           check_ack,
  output int                             pass_count,
  output int                             fail_count
);
  timeunit 1ns;
  timeprecision 1ps;
  import gfx_pkg::*;

  localparam int fb_pixels = fb_width * fb_height;
  localparam int max_shown = 4;  // error lines per test.

  int done_total = 0;
  int bad_total  = 0;

  // pulses counted where they are stable.
  always @(posedge clk) begin
    if (!reset) begin
      done_total <= done_total + int'(done);
      bad_total  <= bad_total + int'(bad_cmd);
    end
  end

  task automatic log_result(input string name, input int errors);
    if (errors == 0) begin
      pass_count++;
      $display("%s: ok", name);
    end else begin
      fail_count++;
      $display("%s: %0d errors", name, errors);
    end
  endtask

  initial begin
    int done_mark;
    int bad_mark;
    int done_seen;
    int bad_seen;
    int errors;
    rd_x       = '0;
    rd_y       = '0;
    check_ack  = 1'b0;
    pass_count = 0;
    fail_count = 0;
    done_mark  = 0;
    bad_mark   = 0;
    do @(negedge clk); while (reset !== 1'b0);
    @(negedge clk);
    errors = 0;
    if (cmd_ready !== 1'b1 || done !== 1'b0 || bad_cmd !== 1'b0) begin
      $display("state after reset is wrong: cmd_ready %b, done %b, bad_cmd %b",
               cmd_ready, done, bad_cmd);
      errors = 1;
    end
    log_result("reset", errors);
    forever begin
      wait (check_req);
      errors    = 0;
      done_seen = done_total - done_mark;
      bad_seen  = bad_total - bad_mark;
      if (exp_done && done_seen == 0) begin
        $display("test %0d: no done came after a valid command", test_num);
        errors++;
      end else if (done_seen != int'(exp_done)) begin
        $display("test %0d: done pulsed %0d times, expected %0d", test_num,
                 done_seen, int'(exp_done));
        errors++;
      end
      if (bad_seen != int'(exp_bad)) begin
        $display("test %0d: bad_cmd pulsed %0d times, expected %0d", test_num,
                 bad_seen, int'(exp_bad));
        errors++;
      end
      if (cmd_ready !== 1'b1) begin
        $display("test %0d: cmd_ready did not come back after the command", test_num);
        errors++;
      end
      // read the whole frame back, one pixel per cycle.
      for (int i = 0; i < fb_pixels; i++) begin
        rd_x = fb_x_bits'(i % fb_width);
        rd_y = fb_y_bits'(i / fb_width);
        @(negedge clk);
        if (rd_color !== model[i]) begin
          if (errors < max_shown) begin
            $display("ERROR at %0d ns: rd_color at (%0d,%0d) is %h, expected %h",
                     $time, rd_x, rd_y, rd_color, model[i]);
          end
          errors++;
        end
      end
      done_mark = done_total;
      bad_mark  = bad_total;
      log_result($sformatf("test %0d", test_num), errors);
      check_ack = 1'b1;
      wait (!check_req);
      check_ack = 1'b0;
    end
  end

endmodule

// ==== testbench/gfx_asserts.sv ====
module gfx_asserts (
  input logic                clk,
  input logic                reset,
  input gfx_pkg::gfx_pixel_t clear_pix,
  input logic                clear_valid,
  input logic                clear_ready,
  input gfx_pkg::gfx_pixel_t rect_pix,
  input logic                rect_valid,
  input logic                rect_ready,
  input logic                clear_start,
  input logic                rect_start,
  input logic                cmd_ready,
  input logic                done
);
  timeunit 1ns;
  timeprecision 1ps;

  // a stalled pixel keeps its valid and payload.
  clear_hold: assert property (@(posedge clk) disable iff (reset)
    clear_valid && !clear_ready |=> clear_valid && $stable(clear_pix))
    else $error("clear stream dropped or changed a pixel before it was taken");

  rect_hold: assert property (@(posedge clk) disable iff (reset)
    rect_valid && !rect_ready |=> rect_valid && $stable(rect_pix))
    else $error("rectangle stream dropped or changed a pixel before it was taken");

  // no new command while a generator is starting or streaming.
  busy_while_drawing: assert property (@(posedge clk) disable iff (reset)
    (clear_start || rect_start || clear_valid || rect_valid) |-> !cmd_ready)
    else $error("cmd_ready is high while a job is being drawn");

  // ready only comes back the cycle after done.
  ready_after_done: assert property (@(posedge clk) disable iff (reset)
    $rose(cmd_ready) |-> $past(done))
    else $error("cmd_ready rose without a done");

  single_done: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else $error("done was high on two cycles in a row");

endmodule

bind gfx_top gfx_asserts asserts0 (
  .clk         (clk),
  .reset       (reset),
  .clear_pix   (clear_pix),
  .clear_valid (clear_valid),
  .clear_ready (clear_ready),
  .rect_pix    (rect_pix),
  .rect_valid  (rect_valid),
  .rect_ready  (rect_ready),
  .clear_start (clear_start),
  .rect_start  (rect_start),
  .cmd_ready   (cmd_ready),
  .done        (done)
);

// ==== source/gfx_top.sv ====
module gfx_top (
  input  logic                           clk,
  input  logic                           reset,
  input  gfx_pkg::gfx_cmd_t              cmd,
  input  logic                           cmd_valid,
  output logic                           cmd_ready,
  input  logic                           stall,
  output logic                           bad_cmd,
  output logic                           done,
  input  logic [gfx_pkg::fb_x_bits-1:0]  rd_x,
  input  logic [gfx_pkg::fb_y_bits-1:0]  rd_y,
  output logic [gfx_pkg::pixel_bits-1:0] rd_color
);
  import gfx_pkg::*;

  gfx_job_t   job;
  logic       clear_start;
  logic       rect_start;

  gfx_pixel_t clear_pix;
  logic       clear_valid;
  logic       clear_ready;
  gfx_pixel_t rect_pix;
  logic       rect_valid;
  logic       rect_ready;

  gfx_cmd_decode decode0 (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .done        (done),
    .cmd_ready   (cmd_ready),
    .job         (job),
    .clear_start (clear_start),
    .rect_start  (rect_start),
    .bad_cmd     (bad_cmd)
  );

  // the two pixel generators.
  gfx_clear clear0 (
    .clk         (clk),
    .reset       (reset),
    .clear_start (clear_start),
    .job         (job),
    .pix_ready   (clear_ready),
    .pix         (clear_pix),
    .pix_valid   (clear_valid)
  );

  gfx_fill_rect rect0 (
    .clk        (clk),
    .reset      (reset),
    .rect_start (rect_start),
    .job        (job),
    .pix_ready  (rect_ready),
    .pix        (rect_pix),
    .pix_valid  (rect_valid)
  );

  gfx_fb_write fb0 (
    .clk         (clk),
    .reset       (reset),
    .clear_pix   (clear_pix),
    .clear_valid (clear_valid),
    .rect_pix    (rect_pix),
    .rect_valid  (rect_valid),
    .stall       (stall),
    .rd_x        (rd_x),
    .rd_y        (rd_y),
    .clear_ready (clear_ready),
    .rect_ready  (rect_ready),
    .done        (done),
    .rd_color    (rd_color)
  );

endmodule

// ==== source/gfx_fb_write.sv ====
module gfx_fb_write (
  input  logic                           clk,
  input  logic                           reset,
  input  gfx_pkg::gfx_pixel_t            clear_pix,
  input  logic                           clear_valid,
  input  gfx_pkg::gfx_pixel_t            rect_pix,
  input  logic                           rect_valid,
  input  logic                           stall,
  input  logic [gfx_pkg::fb_x_bits-1:0]  rd_x,
  input  logic [gfx_pkg::fb_y_bits-1:0]  rd_y,
  output logic                           clear_ready,
  output logic                           rect_ready,
  output logic                           done,
  output logic [gfx_pkg::pixel_bits-1:0] rd_color
);
  import gfx_pkg::*;

  localparam int fb_pixels    = fb_width * fb_height;
  localparam int fb_addr_bits = $clog2(fb_pixels);

  typedef logic [fb_addr_bits-1:0] fb_addr_t;

  logic [pixel_bits-1:0] mem [fb_pixels];  // the framebuffer.

  gfx_pixel_t wr_pix;
  logic       wr_en;
  fb_addr_t   wr_addr;
  fb_addr_t   rd_addr;

  // row major, y * width + x.
  function automatic fb_addr_t fb_addr(input logic [fb_x_bits-1:0] px,
                                       input logic [fb_y_bits-1:0] py);
    return fb_addr_t'(py) * fb_addr_t'(fb_width) + fb_addr_t'(px);
  endfunction

  // ======================================================================
  // stream merge.
  // ======================================================================

  // the generators never run together, so a plain select is enough.
  assign clear_ready = !stall;
  assign rect_ready  = !stall;

  assign wr_pix  = clear_valid ? clear_pix : rect_pix;
  assign wr_en   = (clear_valid || rect_valid) && !stall;  // transfer cycle.
  assign wr_addr = fb_addr(wr_pix.x, wr_pix.y);
  assign rd_addr = fb_addr(rd_x, rd_y);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_pix.color;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= wr_en && wr_pix.last;  // one cycle after the last pixel.
    end
  end

  // ======================================================================
  // scanout read port, one cycle latency.
  // ======================================================================

  always_ff @(posedge clk) begin
    rd_color <= mem[rd_addr];
  end

endmodule

// ==== source/gfx_fill_rect.sv ====
module gfx_fill_rect (
  input  logic                clk,
  input  logic                reset,
  input  logic                rect_start,
  input  gfx_pkg::gfx_job_t   job,
  input  logic                pix_ready,
  output gfx_pkg::gfx_pixel_t pix,
  output logic                pix_valid
);
  import gfx_pkg::*;

  logic [fb_x_bits-1:0]  x;
  logic [fb_y_bits-1:0]  y;
  logic [fb_x_bits-1:0]  left;    // x0, where each row restarts.
  logic [fb_x_bits-1:0]  right;   // x1.
  logic [fb_y_bits-1:0]  bottom;  // y1.
  logic [pixel_bits-1:0] color;
  logic                  xfer;
  logic                  row_end;
  logic                  at_end;

  assign xfer    = pix_valid && pix_ready;
  assign row_end = (x == right);
  assign at_end  = row_end && (y == bottom);

  always_comb begin
    pix.x     = x;
    pix.y     = y;
    pix.color = color;
    pix.last  = at_end;
  end

  // ======================================================================
  // box bounds and color.
  // ======================================================================

  // bounds come checked from decode.
  always_ff @(posedge clk) begin
    if (rect_start) begin
      left   <= job.x0;
      right  <= job.x1;
      bottom <= job.y1;
      color  <= job.color;
    end
  end

  // ======================================================================
  // coordinate walk, raster order inside the box.
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else if (rect_start) begin
      x <= job.x0;  // top left corner.
      y <= job.y0;
    end else if (xfer && !at_end) begin
      if (row_end) begin
        x <= left;
        y <= y + 1'b1;
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_valid <= 1'b0;
    end else if (rect_start) begin
      pix_valid <= 1'b1;
    end else if (xfer && at_end) begin
      pix_valid <= 1'b0;
    end
  end

endmodule

// ==== source/gfx_clear.sv ====
module gfx_clear (
  input  logic                clk,
  input  logic                reset,
  input  logic                clear_start,
  input  gfx_pkg::gfx_job_t   job,
  input  logic                pix_ready,
  output gfx_pkg::gfx_pixel_t pix,
  output logic                pix_valid
);
  import gfx_pkg::*;

  localparam logic [fb_x_bits-1:0] max_x = fb_x_bits'(fb_width - 1);
  localparam logic [fb_y_bits-1:0] max_y = fb_y_bits'(fb_height - 1);

  logic [fb_x_bits-1:0]  x;
  logic [fb_y_bits-1:0]  y;
  logic [pixel_bits-1:0] color;
  logic                  xfer;
  logic                  at_end;

  assign xfer   = pix_valid && pix_ready;
  assign at_end = (x == max_x) && (y == max_y);  // bottom right corner.

  always_comb begin
    pix.x     = x;
    pix.y     = y;
    pix.color = color;
    pix.last  = at_end;
  end

  // ======================================================================
  // raster counter.
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else if (clear_start) begin
      x <= '0;  // always restart at the origin.
      y <= '0;
    end else if (xfer && !at_end) begin
      if (x == max_x) begin
        x <= '0;
        y <= y + 1'b1;  // next row.
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  // stream valid.
  // it stays high across transfers, so pixels go back to back while
  // the writer is ready.
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_valid <= 1'b0;
    end else if (clear_start) begin
      pix_valid <= 1'b1;
    end else if (xfer && at_end) begin
      pix_valid <= 1'b0;  // last pixel taken.
    end
  end

  always_ff @(posedge clk) begin
    if (clear_start) begin
      color <= job.color;  // held for the whole frame.
    end
  end

endmodule

// ==== source/gfx_cmd_decode.sv ====
module gfx_cmd_decode (
  input  logic              clk,
  input  logic              reset,
  input  gfx_pkg::gfx_cmd_t cmd,
  input  logic              cmd_valid,
  input  logic              done,
  output logic              cmd_ready,
  output gfx_pkg::gfx_job_t job,
  output logic              clear_start,
  output logic              rect_start,
  output logic              bad_cmd
);
  import gfx_pkg::*;

  logic busy;         // a job is in flight.
  logic accept;
  logic coord_bad;
  logic cmd_bad;
  logic launch_clear;
  logic launch_rect;

  assign cmd_ready = !busy;
  assign accept    = cmd_valid && cmd_ready;

  // ======================================================================
  // validation, done on the incoming command.
  // ======================================================================

  // coordinates only matter for a rectangle; a clear ignores them.
  always_comb begin
    coord_bad = (int'(cmd.x1) >= fb_width) ||
                (int'(cmd.y1) >= fb_height) ||
                (cmd.x1 < cmd.x0) ||
                (cmd.y1 < cmd.y0);
    cmd_bad      = (cmd.op == op_bad) || ((cmd.op == op_rect) && coord_bad);
    launch_clear = accept && (cmd.op == op_clear);
    launch_rect  = accept && (cmd.op == op_rect) && !coord_bad;
  end

  // ======================================================================
  // pulses and busy flag.
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      clear_start <= 1'b0;
      rect_start  <= 1'b0;
      bad_cmd     <= 1'b0;
      busy        <= 1'b0;
    end else begin
      clear_start <= launch_clear;
      rect_start  <= launch_rect;
      bad_cmd     <= accept && cmd_bad;  // nop leaves every pulse low.
      if (launch_clear || launch_rect) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;  // ready again the cycle after done.
      end
    end
  end

  // job fields are picked up by the generator on its start pulse.
  always_ff @(posedge clk) begin
    if (accept) begin
      job.color <= cmd.color;
      job.x0    <= cmd.x0;
      job.y0    <= cmd.y0;
      job.x1    <= cmd.x1;
      job.y1    <= cmd.y1;
    end
  end

endmodule

// ==== source/gfx_pkg.sv ====
package gfx_pkg;

  // ======================================================================
  // framebuffer geometry.
  // ======================================================================

  localparam int fb_width  = 16;  // pixels per row.
  localparam int fb_height = 12;  // rows.

  localparam int pixel_bits = 4;  // color depth.

  localparam int fb_x_bits = 4;
  localparam int fb_y_bits = 4;

  // ======================================================================
  // host commands.
  // ======================================================================

  // op_bad is reserved and never executes.
  typedef enum logic [1:0] {
    op_nop   = 2'd0,
    op_clear = 2'd1,
    op_rect  = 2'd2,
    op_bad   = 2'd3
  } gfx_op_t;

  typedef struct packed {
    gfx_op_t               op;
    logic [pixel_bits-1:0] color;
    logic [fb_x_bits-1:0]  x0;
    logic [fb_y_bits-1:0]  y0;
    logic [fb_x_bits-1:0]  x1;  // inclusive corner.
    logic [fb_y_bits-1:0]  y1;
  } gfx_cmd_t;

  // a command that passed the checks, handed to a generator.
  typedef struct packed {
    logic [pixel_bits-1:0] color;
    logic [fb_x_bits-1:0]  x0;
    logic [fb_y_bits-1:0]  y0;
    logic [fb_x_bits-1:0]  x1;
    logic [fb_y_bits-1:0]  y1;
  } gfx_job_t;

  // one pixel write on a generator stream.
  typedef struct packed {
    logic [fb_x_bits-1:0]  x;
    logic [fb_y_bits-1:0]  y;
    logic [pixel_bits-1:0] color;
    logic                  last;  // final pixel of the job.
  } gfx_pixel_t;

endpackage
